// File: source/control_pkg.sv
package control_pkg;

    ////////////////////////////////////////
    // reset stretching
    ////////////////////////////////////////

    // cycles a console reset stays low after its request ends
    // scaled down for simulation, hardware runs far longer
    localparam int RESET_HOLD_CYCLES = 200;

    // hold counter wide enough to reach RESET_HOLD_CYCLES
    localparam int HOLD_COUNT_WIDTH = $clog2(RESET_HOLD_CYCLES + 1);

    ////////////////////////////////////////
    // status led timing
    ////////////////////////////////////////

    // top counter bit of each glow generator
    localparam int SLOW_GLOW_BIT = 12;
    localparam int FAST_GLOW_BIT = 9;

    // status counter bit gating the force-generate blink
    localparam int BLINK_BIT = 10;

    ////////////////////////////////////////
    // clock domain crossing
    ////////////////////////////////////////

    // flops in each input synchronizer
    localparam int SYNC_STAGES = 2;

    ////////////////////////////////////////
    // led_mode encodings
    ////////////////////////////////////////

    // normal video status display
    localparam logic [1:0] LED_MODE_STATUS = 2'd0;

    // mirror the console reset line
    localparam logic [1:0] LED_MODE_DC_RESET = 2'd2;

    // any other value mirrors the optional reset line

endpackage

// File: source/signal_sync.sv
module signal_sync import control_pkg::*; (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic async_in,
    output logic level,
    output logic rise,
    output logic fall
);

    // first stage samples the foreign domain
    logic [SYNC_STAGES-1:0] chain;

    // level as seen one cycle earlier
    logic level_prev;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            chain      <= '0;
            level_prev <= 1'b0;
        end else begin
            chain      <= {chain[SYNC_STAGES-2:0], async_in};
            level_prev <= chain[SYNC_STAGES-1];
        end
    end

    assign level = chain[SYNC_STAGES-1];

    // one cycle pulses, right after level changes
    assign rise = level & ~level_prev;
    assign fall = ~level & level_prev;

endmodule

// File: source/reset_hold.sv
module reset_hold import control_pkg::*; (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic request,
    output logic nreset
);

    localparam logic [HOLD_COUNT_WIDTH-1:0] hold_limit =
        HOLD_COUNT_WIDTH'(RESET_HOLD_CYCLES);

    // cycles since the request dropped, stops at hold_limit
    logic [HOLD_COUNT_WIDTH-1:0] hold_count;

    logic hold_done;

    assign hold_done = (hold_count == hold_limit);

    always_ff @(posedge control_clock) begin
        if (request) begin
            // request wins even during reset
            hold_count <= '0;
            nreset     <= 1'b0;
        end else if (reset_dc) begin
            // no request pending, start released
            hold_count <= hold_limit;
            nreset     <= 1'b1;
        end else begin
            if (!hold_done) begin
                hold_count <= hold_count + 1'b1;
            end
            // release one edge after the limit is reached
            if (hold_done) begin
                nreset <= 1'b1;
            end
        end
    end

endmodule

// File: source/led_glow.sv
module led_glow #(
    parameter int glow_bit = 12
) (
    input  logic control_clock,
    input  logic reset_dc,
    output logic glow
);

    // eight brightness bits sit right below the direction bit
    localparam int level_width = 8;
    localparam int level_low   = glow_bit - level_width;

    // free running phase counter
    logic [glow_bit:0] phase;

    // current brightness and the pwm ramp it is compared against
    logic [level_width-1:0] brightness_raw;
    logic [level_width-1:0] brightness;
    logic [level_width-1:0] pwm_ramp;
    logic                   falling;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    ////////////////////////////////////////
    // triangle brightness
    ////////////////////////////////////////

    assign brightness_raw = phase[level_low +: level_width];
    assign falling        = phase[glow_bit];

    // second half of each period runs the ramp back down
    assign brightness = falling ? ~brightness_raw : brightness_raw;

    ////////////////////////////////////////
    // pwm output
    ////////////////////////////////////////

    assign pwm_ramp = phase[level_width-1:0];

    // on while the fast ramp is below the brightness
    assign glow = (pwm_ramp < brightness);

endmodule

// File: source/status_led.sv
module status_led import control_pkg::*; (
    input  logic       control_clock,
    input  logic       reset_dc,
    input  logic [1:0] led_mode,
    input  logic       pll_hdmi_ready,
    input  logic       resync,
    input  logic       force_generate,
    input  logic       encoder_ready,
    input  logic       slow_glow,
    input  logic       fast_glow,
    input  logic       dc_nreset,
    input  logic       opt_nreset,
    output logic       level,
    output logic       oe
);

    // free running counter, its top bit paces the blink
    logic [BLINK_BIT:0] blink_count;
    logic               blink_on;

    // next state of the led pin
    logic status_level;
    logic next_level;
    logic next_oe;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            blink_count <= '0;
        end else begin
            blink_count <= blink_count + 1'b1;
        end
    end

    assign blink_on = blink_count[BLINK_BIT];

    ////////////////////////////////////////
    // status display, led is active low
    ////////////////////////////////////////

    always_comb begin
        if (!pll_hdmi_ready) begin
            // no hdmi clock yet, led dark
            status_level = 1'b1;
        end else if (resync) begin
            status_level = ~fast_glow;
        end else if (force_generate) begin
            // glow in bursts while video is generated internally
            status_level = blink_on ? ~fast_glow : 1'b1;
        end else if (encoder_ready) begin
            status_level = 1'b0;
        end else begin
            status_level = ~slow_glow;
        end
    end

    ////////////////////////////////////////
    // mode select
    ////////////////////////////////////////

    always_comb begin
        if (led_mode == LED_MODE_STATUS) begin
            next_level = status_level;
            next_oe    = 1'b1;
        end else if (led_mode == LED_MODE_DC_RESET) begin
            // pull low together with the console reset
            next_level = 1'b0;
            next_oe    = ~dc_nreset;
        end else begin
            next_level = 1'b0;
            next_oe    = ~opt_nreset;
        end
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            level <= 1'b1;
            oe    <= 1'b0;
        end else begin
            level <= next_level;
            oe    <= next_oe;
        end
    end

endmodule

// File: source/reset_control_top.sv
module reset_control_top import control_pkg::*; (
    input  logic       control_clock,
    input  logic       reset_dc,
    input  logic       reset_opt,
    input  logic [1:0] led_mode,
    input  logic       pll_video_locked,
    input  logic       pll_hdmi_locked,
    input  logic       resync_flag,
    input  logic       force_generate_flag,
    input  logic       encoder_ready,
    output logic       dc_reset_pull,
    output logic       opt_reset_pull,
    output logic       status_led_level,
    output logic       status_led_oe,
    output logic       pll_reset_pulse,
    output logic       pll_hdmi_ready
);

    logic video_lock_fall;
    logic hdmi_lock_fall;
    logic resync;
    logic force_generate;

    logic dc_nreset;
    logic opt_nreset;

    logic slow_glow;
    logic fast_glow;

    ////////////////////////////////////////
    // inputs from other clock domains
    ////////////////////////////////////////

    signal_sync video_lock_sync (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .async_in      (pll_video_locked),
        .level         (),
        .rise          (),
        .fall          (video_lock_fall)
    );

    signal_sync hdmi_lock_sync (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .async_in      (pll_hdmi_locked),
        .level         (pll_hdmi_ready),
        .rise          (),
        .fall          (hdmi_lock_fall)
    );

    signal_sync resync_sync (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .async_in      (resync_flag),
        .level         (resync),
        .rise          (),
        .fall          ()
    );

    signal_sync force_generate_sync (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .async_in      (force_generate_flag),
        .level         (force_generate),
        .rise          (),
        .fall          ()
    );

    // lost lock on either pll restarts the reconfiguration
    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pll_reset_pulse <= 1'b0;
        end else begin
            pll_reset_pulse <= video_lock_fall | hdmi_lock_fall;
        end
    end

    ////////////////////////////////////////
    // console reset lines
    ////////////////////////////////////////

    reset_hold dc_hold (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (reset_dc),
        .nreset        (dc_nreset)
    );

    reset_hold opt_hold (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (reset_opt),
        .nreset        (opt_nreset)
    );

    // open drain, 1 pulls the line low
    assign dc_reset_pull  = ~dc_nreset;
    assign opt_reset_pull = ~opt_nreset;

    ////////////////////////////////////////
    // status led
    ////////////////////////////////////////

    led_glow #(
        .glow_bit (SLOW_GLOW_BIT)
    ) slow_glow_gen (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (slow_glow)
    );

    led_glow #(
        .glow_bit (FAST_GLOW_BIT)
    ) fast_glow_gen (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (fast_glow)
    );

    status_led led_control (
        .control_clock  (control_clock),
        .reset_dc       (reset_dc),
        .led_mode       (led_mode),
        .pll_hdmi_ready (pll_hdmi_ready),
        .resync         (resync),
        .force_generate (force_generate),
        .encoder_ready  (encoder_ready),
        .slow_glow      (slow_glow),
        .fast_glow      (fast_glow),
        .dc_nreset      (dc_nreset),
        .opt_nreset     (opt_nreset),
        .level          (status_led_level),
        .oe             (status_led_oe)
    );

endmodule

// File: bench/clock_gen.sv
module clock_gen #(
    parameter int half_period = 20,
    parameter int reset_cycles = 2
) (
    output logic control_clock,
    output logic power_on_reset
);

    initial begin
        control_clock = 1'b0;
        forever begin
            #half_period control_clock = ~control_clock;
        end
    end

    // release a little after the last reset edge
    initial begin
        power_on_reset = 1'b1;
        repeat (reset_cycles) @(posedge control_clock);
        #5 power_on_reset = 1'b0;
    end

endmodule

// File: bench/reset_control_chk.sv
module reset_control_chk import control_pkg::*; (
    input logic       control_clock,
    input logic       reset_dc,
    input logic       reset_opt,
    input logic [1:0] led_mode,
    input logic       pll_video_locked,
    input logic       pll_hdmi_locked,
    input logic       resync_flag,
    input logic       force_generate_flag,
    input logic       encoder_ready,
    input logic       dc_reset_pull,
    input logic       opt_reset_pull,
    input logic       status_led_level,
    input logic       status_led_oe,
    input logic       pll_reset_pulse,
    input logic       pll_hdmi_ready
);

    // one flag per assertion, the bench watches their union
    logic err_dc = 1'b0;
    logic err_opt = 1'b0;
    logic err_pulse = 1'b0;
    logic err_ready = 1'b0;
    logic err_level = 1'b0;
    logic err_oe = 1'b0;
    logic error_seen;

    logic model_valid = 1'b0;

    int   dc_low_count;
    int   opt_low_count;
    logic exp_dc_pull;
    logic exp_opt_pull;

    // synchronizer models, index 1 is the synced level
    logic [1:0] video_sync;
    logic [1:0] hdmi_sync;
    logic [1:0] resync_sync;
    logic [1:0] force_sync;
    logic       video_prev;
    logic       hdmi_prev;
    logic       exp_pulse;

    logic [12:0] slow_count;
    logic [9:0]  fast_count;
    logic [10:0] blink_count;
    logic        slow_on;
    logic        fast_on;
    logic        status_model;
    logic        exp_level;
    logic        exp_oe;

    assign error_seen = err_dc | err_opt | err_pulse | err_ready | err_level | err_oe;

    ////////////////////////////////////////
    // glow and status reference
    ////////////////////////////////////////

    // triangle brightness against the low byte of the counter
    always_comb begin
        logic [7:0] slow_bright;
        logic [7:0] fast_bright;
        slow_bright = slow_count[12] ? ~slow_count[11:4] : slow_count[11:4];
        fast_bright = fast_count[9] ? ~fast_count[8:1] : fast_count[8:1];
        slow_on = slow_count[7:0] < slow_bright;
        fast_on = fast_count[7:0] < fast_bright;
        if (!hdmi_sync[1]) begin
            status_model = 1'b1;
        end else if (resync_sync[1]) begin
            status_model = !fast_on;
        end else if (force_sync[1]) begin
            status_model = blink_count[10] ? !fast_on : 1'b1;
        end else if (encoder_ready) begin
            status_model = 1'b0;
        end else begin
            status_model = !slow_on;
        end
    end

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            model_valid <= 1'b1;
            video_sync  <= '0;
            hdmi_sync   <= '0;
            resync_sync <= '0;
            force_sync  <= '0;
            video_prev  <= 1'b0;
            hdmi_prev   <= 1'b0;
            exp_pulse   <= 1'b0;
            slow_count  <= '0;
            fast_count  <= '0;
            blink_count <= '0;
            exp_level   <= 1'b1;
            exp_oe      <= 1'b0;
        end else begin
            video_sync  <= {video_sync[0], pll_video_locked};
            hdmi_sync   <= {hdmi_sync[0], pll_hdmi_locked};
            resync_sync <= {resync_sync[0], resync_flag};
            force_sync  <= {force_sync[0], force_generate_flag};
            video_prev  <= video_sync[1];
            hdmi_prev   <= hdmi_sync[1];
            exp_pulse   <= (!video_sync[1] && video_prev) || (!hdmi_sync[1] && hdmi_prev);
            slow_count  <= slow_count + 1'b1;
            fast_count  <= fast_count + 1'b1;
            blink_count <= blink_count + 1'b1;
            if (led_mode == 2'd0) begin
                exp_level <= status_model;
                exp_oe    <= 1'b1;
            end else if (led_mode == 2'd2) begin
                exp_level <= 1'b0;
                exp_oe    <= exp_dc_pull;
            end else begin
                exp_level <= 1'b0;
                exp_oe    <= exp_opt_pull;
            end
        end
    end

    ////////////////////////////////////////
    // reset stretch reference
    ////////////////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            dc_low_count <= 0;
            exp_dc_pull  <= 1'b1;
        end else if (dc_low_count == RESET_HOLD_CYCLES) begin
            exp_dc_pull <= 1'b0;
        end else begin
            dc_low_count <= dc_low_count + 1;
        end

        if (reset_opt) begin
            opt_low_count <= 0;
            exp_opt_pull  <= 1'b1;
        end else if (reset_dc) begin
            opt_low_count <= RESET_HOLD_CYCLES;
            exp_opt_pull  <= 1'b0;
        end else if (opt_low_count == RESET_HOLD_CYCLES) begin
            exp_opt_pull <= 1'b0;
        end else begin
            opt_low_count <= opt_low_count + 1;
        end
    end

    ////////////////////////////////////////
    // assertions
    ////////////////////////////////////////

    dc_pull_a: assert property (@(posedge control_clock) disable iff (!model_valid)
        dc_reset_pull == exp_dc_pull)
    else begin
        err_dc = 1'b1;
        $error("[ERROR] console_reset expected %0d actual %0d", exp_dc_pull, dc_reset_pull);
    end

    opt_pull_a: assert property (@(posedge control_clock) disable iff (!model_valid)
        opt_reset_pull == exp_opt_pull)
    else begin
        err_opt = 1'b1;
        $error("[ERROR] optional_reset expected %0d actual %0d", exp_opt_pull, opt_reset_pull);
    end

    pulse_a: assert property (@(posedge control_clock) disable iff (!model_valid)
        pll_reset_pulse == exp_pulse)
    else begin
        err_pulse = 1'b1;
        $error("[ERROR] lock_loss expected %0d actual %0d", exp_pulse, pll_reset_pulse);
    end

    ready_a: assert property (@(posedge control_clock) disable iff (!model_valid)
        pll_hdmi_ready == hdmi_sync[1])
    else begin
        err_ready = 1'b1;
        $error("[ERROR] hdmi_ready expected %0d actual %0d", hdmi_sync[1], pll_hdmi_ready);
    end

    level_a: assert property (@(posedge control_clock) disable iff (!model_valid)
        status_led_level == exp_level)
    else begin
        err_level = 1'b1;
        $error("[ERROR] led_level expected %0d actual %0d", exp_level, status_led_level);
    end

    oe_a: assert property (@(posedge control_clock) disable iff (!model_valid)
        status_led_oe == exp_oe)
    else begin
        err_oe = 1'b1;
        $error("[ERROR] led_oe expected %0d actual %0d", exp_oe, status_led_oe);
    end

endmodule

bind reset_control_top reset_control_chk chk (
    .control_clock       (control_clock),
    .reset_dc            (reset_dc),
    .reset_opt           (reset_opt),
    .led_mode            (led_mode),
    .pll_video_locked    (pll_video_locked),
    .pll_hdmi_locked     (pll_hdmi_locked),
    .resync_flag         (resync_flag),
    .force_generate_flag (force_generate_flag),
    .encoder_ready       (encoder_ready),
    .dc_reset_pull       (dc_reset_pull),
    .opt_reset_pull      (opt_reset_pull),
    .status_led_level    (status_led_level),
    .status_led_oe       (status_led_oe),
    .pll_reset_pulse     (pll_reset_pulse),
    .pll_hdmi_ready      (pll_hdmi_ready)
);

// File: bench/control_tb.sv
module control_tb;

    localparam int cycle_limit = 8000;
    localparam int wait_limit = 400;

    logic       control_clock;
    logic       power_on_reset;
    logic       extra_reset;
    logic       reset_dc;
    logic       reset_opt;
    logic [1:0] led_mode;
    logic       pll_video_locked;
    logic       pll_hdmi_locked;
    logic       resync_flag;
    logic       force_generate_flag;
    logic       encoder_ready;
    logic       dc_reset_pull;
    logic       opt_reset_pull;
    logic       status_led_level;
    logic       status_led_oe;
    logic       pll_reset_pulse;
    logic       pll_hdmi_ready;

    int seed;
    int cycle_count;

    assign reset_dc = power_on_reset | extra_reset;

    clock_gen clocks (
        .control_clock  (control_clock),
        .power_on_reset (power_on_reset)
    );

    reset_control_top i_reset_control_top (
        .control_clock       (control_clock),
        .reset_dc            (reset_dc),
        .reset_opt           (reset_opt),
        .led_mode            (led_mode),
        .pll_video_locked    (pll_video_locked),
        .pll_hdmi_locked     (pll_hdmi_locked),
        .resync_flag         (resync_flag),
        .force_generate_flag (force_generate_flag),
        .encoder_ready       (encoder_ready),
        .dc_reset_pull       (dc_reset_pull),
        .opt_reset_pull      (opt_reset_pull),
        .status_led_level    (status_led_level),
        .status_led_oe       (status_led_oe),
        .pll_reset_pulse     (pll_reset_pulse),
        .pll_hdmi_ready      (pll_hdmi_ready)
    );

    // run limit and assertion watch
    always @(posedge control_clock) begin
        cycle_count <= cycle_count + 1;
        if (i_reset_control_top.chk.error_seen) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "assertion failure in reset control checker");
        end else if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic step(input int n);
        repeat (n) @(posedge control_clock);
        #5;
    endtask

    // wait for a pull line to release, bounded
    task automatic wait_release(input bit opt_line);
        int waited;
        waited = 0;
        while ((opt_line ? opt_reset_pull : dc_reset_pull) !== 1'b0) begin
            step(1);
            waited++;
            if (waited > wait_limit) begin
                $display("reset line never released");
                $display("TEST RESULT: FAIL");
                $fatal(1, "release wait");
            end
        end
        step(3);
    endtask

    task automatic pulse_opt_reset();
        reset_opt = 1'b1;
        step(1 + ($unsigned($random(seed)) % 20));
        reset_opt = 1'b0;
        wait_release(1'b1);
    endtask

    initial begin
        seed                = 70915;
        extra_reset         = 1'b0;
        reset_opt           = 1'b0;
        led_mode            = 2'd0;
        pll_video_locked    = 1'b0;
        pll_hdmi_locked     = 1'b0;
        resync_flag         = 1'b0;
        force_generate_flag = 1'b0;
        encoder_ready       = 1'b0;

        wait (power_on_reset == 1'b0);
        step(1);

        // console reset and restart of the hold
        wait_release(1'b0);
        extra_reset = 1'b1;
        step(3);
        extra_reset = 1'b0;
        wait_release(1'b0);

        // optional reset with random lengths
        repeat (2) begin
            pulse_opt_reset();
        end

        // lock losses at random spacing, each pll in turn
        for (int lock_round = 0; lock_round < 4; lock_round++) begin
            pll_video_locked = 1'b1;
            pll_hdmi_locked  = 1'b1;
            step(4 + ($unsigned($random(seed)) % 16));
            if (lock_round % 2 == 0) begin
                pll_video_locked = 1'b0;
            end else begin
                pll_hdmi_locked = 1'b0;
            end
            step(4 + ($unsigned($random(seed)) % 16));
        end

        // status priority in mode 0, dropping one source at a time
        pll_hdmi_locked     = 1'b0;
        resync_flag         = 1'b1;
        force_generate_flag = 1'b1;
        encoder_ready       = 1'b1;
        step(300);
        pll_hdmi_locked = 1'b1;
        step(1200);
        resync_flag = 1'b0;
        step(1200);
        force_generate_flag = 1'b0;
        step(300);
        encoder_ready = 1'b0;
        step(300);

        // mirror modes
        led_mode    = 2'd2;
        extra_reset = 1'b1;
        step(2);
        extra_reset = 1'b0;
        wait_release(1'b0);
        led_mode = 2'd1;
        pulse_opt_reset();
        led_mode = 2'd3;
        pulse_opt_reset();
        step(2);

        if (i_reset_control_top.chk.error_seen) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "assertion failure in reset control checker");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: src.f
source/control_pkg.sv
source/signal_sync.sv
source/reset_hold.sv
source/led_glow.sv
source/status_led.sv
source/reset_control_top.sv
bench/clock_gen.sv
bench/reset_control_chk.sv
bench/control_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module control_tb \
    -f src.f \
    -o control_sim

# the simulator exits nonzero on a fatal, the log decides the result
./obj_dir/control_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
